/* rtl/z80OpcodePkg.sv */
package z80OpcodePkg;

	// Instruction byte as seen on the data bus
	typedef logic [7:0] opcode_t;

	// Micro-address into the microcode ROM
	typedef logic [8:0] uAddr_t;

	//////////////////////////////
	// Main opcode map
	//////////////////////////////
	localparam opcode_t OpNop      = 8'h00;
	localparam opcode_t OpDi       = 8'hF3;
	localparam opcode_t OpLdAn     = 8'h3E;
	localparam opcode_t OpLdBn     = 8'h06;
	localparam opcode_t OpLdCn     = 8'h0E;
	localparam opcode_t OpIncC     = 8'h0C;
	localparam opcode_t OpDecA     = 8'h3D;
	localparam opcode_t OpAddB     = 8'h80;
	localparam opcode_t OpSubB     = 8'h90;
	localparam opcode_t OpJr       = 8'h18;
	localparam opcode_t OpJrNz     = 8'h20;
	localparam opcode_t OpJrZ      = 8'h28;
	localparam opcode_t OpCbPrefix = 8'hCB;

	// Second byte after the CB prefix
	localparam opcode_t CbBit7H = 8'h7C;
	localparam opcode_t CbRlB   = 8'h10;
	localparam opcode_t CbSrlB  = 8'h38;

	//////////////////////////////
	// Flow entry points in the ROM
	//////////////////////////////
	localparam uAddr_t FlowDefault  = 9'd0;
	localparam uAddr_t FlowNop      = 9'd2;
	localparam uAddr_t FlowDi       = 9'd3;
	localparam uAddr_t FlowLdAn     = 9'd4;
	localparam uAddr_t FlowLdBn     = 9'd7;
	localparam uAddr_t FlowLdCn     = 9'd10;
	localparam uAddr_t FlowIncC     = 9'd13;
	localparam uAddr_t FlowDecA     = 9'd14;
	localparam uAddr_t FlowAddB     = 9'd15;
	localparam uAddr_t FlowSubB     = 9'd18;
	localparam uAddr_t FlowJr       = 9'd21;
	localparam uAddr_t FlowJrNz     = 9'd27;
	localparam uAddr_t FlowJrZ      = 9'd33;
	localparam uAddr_t FlowCbPrefix = 9'd39;
	localparam uAddr_t FlowCbBit    = 9'd42;
	localparam uAddr_t FlowCbRl     = 9'd43;
	localparam uAddr_t FlowCbSrl    = 9'd45;
	// Highest populated ROM slot
	localparam uAddr_t FlowLast     = 9'd46;

endpackage

/* rtl/ucodePkg.sv */
package ucodePkg;

	//////////////////////////////
	// Flow control kinds
	//////////////////////////////
	typedef enum logic [3:0]
	{
		FcOp,
		FcInc,
		FcEof,
		FcIncEof,
		FcEofFu,
		FcIncEofFu,
		// Conditional ends, zero flag driven
		FcIncEofZ,
		FcIncEofNz,
		// Jump into the CB table
		FcJcb,
		FcUpdateFlags
	} flowCtl_e;

	// Datapath commands
	typedef enum logic [4:0]
	{
		CmdNop,
		CmdSma,
		CmdSrm,
		CmdSx16r,
		CmdAddx16,
		CmdAddx16u,
		CmdSubx16,
		CmdInc16,
		CmdDec16,
		CmdSpc,
		CmdCeti,
		CmdBit,
		CmdShl,
		CmdShr,
		CmdZ801bop
	} uopCmd_e;

	// Operand select
	typedef enum logic [5:0]
	{
		OpdNull,
		OpdA,
		OpdB,
		OpdC,
		OpdH,
		OpdPc,
		OpdX8,
		OpdX16
	} uopOperand_e;

	// One ROM word, 15 bits
	typedef struct packed
	{
		flowCtl_e    flowCtl;
		uopCmd_e     cmd;
		uopOperand_e operand;
	} uop_t;

	typedef struct packed
	{
		logic zero;
		logic carry;
	} flags_t;

endpackage

/* rtl/opcodeDecodeLut.sv */
`timescale 1ns/1ps

module opcodeDecodeLut
(
	input  z80OpcodePkg::opcode_t mop,
	output z80OpcodePkg::uAddr_t  flowStart
);

	import z80OpcodePkg::*;

	// Main opcode byte to flow entry
	always_comb
	begin
		case (mop)
			OpNop:      flowStart = FlowNop;
			OpDi:       flowStart = FlowDi;
			OpLdAn:     flowStart = FlowLdAn;
			OpLdBn:     flowStart = FlowLdBn;
			OpLdCn:     flowStart = FlowLdCn;
			OpIncC:     flowStart = FlowIncC;
			OpDecA:     flowStart = FlowDecA;
			OpAddB:     flowStart = FlowAddB;
			OpSubB:     flowStart = FlowSubB;
			// Relative jumps
			OpJr:       flowStart = FlowJr;
			OpJrNz:     flowStart = FlowJrNz;
			OpJrZ:      flowStart = FlowJrZ;
			// Fetches the second byte, then FcJcb
			OpCbPrefix: flowStart = FlowCbPrefix;
			// Generic one byte op
			default:
			begin
				flowStart = FlowDefault;
			end
		endcase
	end

endmodule

/* rtl/cbDecodeLut.sv */
`timescale 1ns/1ps

module cbDecodeLut
(
	input  z80OpcodePkg::opcode_t mop,
	output z80OpcodePkg::uAddr_t  cbFlowStart
);

	import z80OpcodePkg::*;

	// Byte following 0xCB
	always_comb
	begin
		case (mop)
			CbBit7H: cbFlowStart = FlowCbBit;
			CbRlB:   cbFlowStart = FlowCbRl;
			CbSrlB:  cbFlowStart = FlowCbSrl;
			// Unknown extended op falls back to the one byte flow
			default:
			begin
				cbFlowStart = FlowDefault;
			end
		endcase
	end

endmodule

/* rtl/ucodeRom.sv */
`timescale 1ns/1ps

module ucodeRom
#(
	parameter int UcodeAddrWidth = 9
)
(
	input  logic [UcodeAddrWidth-1:0] uAddr,
	output ucodePkg::uop_t            uop
);

	import z80OpcodePkg::*;
	import ucodePkg::*;

	uAddr_t romAddr;
	logic   inRange;

	// Wider address buses only see the populated slots
	assign inRange = 32'(uAddr) <= 32'(FlowLast);
	assign romAddr = uAddr_t'(uAddr);

	always_comb
	begin
		uop = '{FcOp, CmdNop, OpdNull};
		if (inRange)
		begin
			case (romAddr)
				// Default one byte op
				FlowDefault:          uop = '{FcUpdateFlags, CmdZ801bop, OpdA};
				FlowDefault + 9'd1:   uop = '{FcIncEof, CmdNop, OpdNull};
				FlowNop:              uop = '{FcIncEof, CmdNop, OpdNull};
				FlowDi:               uop = '{FcIncEof, CmdCeti, OpdNull};
				//////////////////////////////
				// LD r,n
				//////////////////////////////
				FlowLdAn:             uop = '{FcInc, CmdSma, OpdPc};
				FlowLdAn + 9'd1:      uop = '{FcInc, CmdNop, OpdNull};
				FlowLdAn + 9'd2:      uop = '{FcEof, CmdSrm, OpdA};
				FlowLdBn:             uop = '{FcInc, CmdSma, OpdPc};
				FlowLdBn + 9'd1:      uop = '{FcInc, CmdNop, OpdNull};
				FlowLdBn + 9'd2:      uop = '{FcEof, CmdSrm, OpdB};
				FlowLdCn:             uop = '{FcInc, CmdSma, OpdPc};
				FlowLdCn + 9'd1:      uop = '{FcInc, CmdNop, OpdNull};
				FlowLdCn + 9'd2:      uop = '{FcEof, CmdSrm, OpdC};
				// Single uop ALU ops with flag update
				FlowIncC:             uop = '{FcIncEofFu, CmdInc16, OpdC};
				FlowDecA:             uop = '{FcIncEofFu, CmdDec16, OpdA};
				// A through x16, then back
				FlowAddB:             uop = '{FcOp, CmdSx16r, OpdA};
				FlowAddB + 9'd1:      uop = '{FcUpdateFlags, CmdAddx16u, OpdB};
				FlowAddB + 9'd2:      uop = '{FcIncEof, CmdSrm, OpdA};
				FlowSubB:             uop = '{FcOp, CmdSx16r, OpdA};
				FlowSubB + 9'd1:      uop = '{FcUpdateFlags, CmdSubx16, OpdB};
				FlowSubB + 9'd2:      uop = '{FcIncEof, CmdSrm, OpdA};
				//////////////////////////////
				// Relative jumps
				//////////////////////////////
				FlowJr:               uop = '{FcInc, CmdSma, OpdPc};
				FlowJr + 9'd1:        uop = '{FcOp, CmdNop, OpdNull};
				FlowJr + 9'd2:        uop = '{FcInc, CmdSrm, OpdX8};
				FlowJr + 9'd3:        uop = '{FcOp, CmdSx16r, OpdPc};
				FlowJr + 9'd4:        uop = '{FcOp, CmdAddx16, OpdX8};
				FlowJr + 9'd5:        uop = '{FcEof, CmdSpc, OpdX16};
				// Not taken when Z is set
				FlowJrNz:             uop = '{FcInc, CmdSma, OpdPc};
				FlowJrNz + 9'd1:      uop = '{FcOp, CmdNop, OpdNull};
				FlowJrNz + 9'd2:      uop = '{FcIncEofZ, CmdSrm, OpdX8};
				FlowJrNz + 9'd3:      uop = '{FcOp, CmdSx16r, OpdPc};
				FlowJrNz + 9'd4:      uop = '{FcOp, CmdAddx16, OpdX8};
				FlowJrNz + 9'd5:      uop = '{FcEof, CmdSpc, OpdX16};
				// Not taken when Z is clear
				FlowJrZ:              uop = '{FcInc, CmdSma, OpdPc};
				FlowJrZ + 9'd1:       uop = '{FcOp, CmdNop, OpdNull};
				FlowJrZ + 9'd2:       uop = '{FcIncEofNz, CmdSrm, OpdX8};
				FlowJrZ + 9'd3:       uop = '{FcOp, CmdSx16r, OpdPc};
				FlowJrZ + 9'd4:       uop = '{FcOp, CmdAddx16, OpdX8};
				FlowJrZ + 9'd5:       uop = '{FcEof, CmdSpc, OpdX16};
				//////////////////////////////
				// CB prefix and extended ops
				//////////////////////////////
				FlowCbPrefix:         uop = '{FcInc, CmdSma, OpdPc};
				FlowCbPrefix + 9'd1:  uop = '{FcOp, CmdNop, OpdNull};
				FlowCbPrefix + 9'd2:  uop = '{FcJcb, CmdNop, OpdNull};
				FlowCbBit:            uop = '{FcEofFu, CmdBit, OpdNull};
				FlowCbRl:             uop = '{FcUpdateFlags, CmdShl, OpdNull};
				FlowCbRl + 9'd1:      uop = '{FcEof, CmdNop, OpdNull};
				FlowCbSrl:            uop = '{FcUpdateFlags, CmdShr, OpdNull};
				FlowCbSrl + 9'd1:     uop = '{FcEof, CmdNop, OpdNull};
				default:
				begin
					uop = '{FcOp, CmdNop, OpdNull};
				end
			endcase
		end
	end

endmodule

/* rtl/ucodeSequencer.sv */
`timescale 1ns/1ps

module ucodeSequencer
#(
	parameter int UcodeAddrWidth = 9
)
(
	input  logic                      clock,
	input  logic                      reset,
	input  ucodePkg::uop_t            uop,
	input  ucodePkg::flags_t          flags,
	input  z80OpcodePkg::uAddr_t      flowStart,
	input  z80OpcodePkg::uAddr_t      cbFlowStart,
	output logic [UcodeAddrWidth-1:0] uAddr,
	output logic                      pcIncrement,
	output logic                      flowEnd
);

	import z80OpcodePkg::*;
	import ucodePkg::*;

	logic                      incKind;
	logic                      eofKind;
	logic                      jcbKind;
	logic [UcodeAddrWidth-1:0] nextAddr;

	//////////////////////////////
	// Flow control decode
	//////////////////////////////
	always_comb
	begin
		incKind = 1'b0;
		eofKind = 1'b0;
		jcbKind = 1'b0;
		case (uop.flowCtl)
			FcInc:      incKind = 1'b1;
			FcEof:      eofKind = 1'b1;
			FcIncEof:
			begin
				incKind = 1'b1;
				eofKind = 1'b1;
			end
			FcEofFu:    eofKind = 1'b1;
			FcIncEofFu:
			begin
				incKind = 1'b1;
				eofKind = 1'b1;
			end
			// Conditional end on the zero flag
			FcIncEofZ:
			begin
				incKind = 1'b1;
				eofKind = flags.zero;
			end
			FcIncEofNz:
			begin
				incKind = 1'b1;
				eofKind = !flags.zero;
			end
			FcJcb:
			begin
				incKind = 1'b1;
				jcbKind = 1'b1;
			end
			default:
			begin
				incKind = 1'b0;
			end
		endcase
	end

	// End of flow wins over the CB jump
	always_comb
	begin
		if (eofKind)
			nextAddr = UcodeAddrWidth'(flowStart);
		else if (jcbKind)
			nextAddr = UcodeAddrWidth'(cbFlowStart);
		else
			nextAddr = uAddr + UcodeAddrWidth'(1);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			uAddr <= UcodeAddrWidth'(FlowNop);
		else
			uAddr <= nextAddr;
	end

	// NOP sits at uAddr while reset is held, so mask the strobes
	assign pcIncrement = !reset && incKind;
	assign flowEnd     = !reset && eofKind;

	//////////////////////////////
	// Checks
	//////////////////////////////
	addrInRange: assert property (@(posedge clock) disable iff (reset)
		32'(uAddr) <= 32'(FlowLast))
		else $error("uAddr %0d beyond last flow slot", uAddr);

endmodule

/* rtl/cpuMicrosequencer.sv */
`timescale 1ns/1ps

module cpuMicrosequencer
#(
	parameter int UcodeAddrWidth = 9
)
(
	input  logic                  clock,
	input  logic                  reset,
	input  z80OpcodePkg::opcode_t mop,
	input  ucodePkg::flags_t      flags,
	output ucodePkg::uop_t        uop,
	output logic                  pcIncrement,
	output logic                  flowEnd
);

	import z80OpcodePkg::*;

	uAddr_t                    flowStart;
	uAddr_t                    cbFlowStart;
	logic [UcodeAddrWidth-1:0] uAddr;

	// Both tables look at the same bus byte
	opcodeDecodeLut i_opcodeDecodeLut (.mop(mop), .flowStart(flowStart));

	cbDecodeLut i_cbDecodeLut (.mop(mop), .cbFlowStart(cbFlowStart));

	ucodeRom #(.UcodeAddrWidth(UcodeAddrWidth)) i_ucodeRom (.uAddr(uAddr), .uop(uop));

	ucodeSequencer #(.UcodeAddrWidth(UcodeAddrWidth)) i_ucodeSequencer
	(
		.clock(clock), .reset(reset), .uop(uop), .flags(flags),
		.flowStart(flowStart), .cbFlowStart(cbFlowStart),
		.uAddr(uAddr), .pcIncrement(pcIncrement), .flowEnd(flowEnd)
	);

endmodule

/* tb/tbCpuMicrosequencer.sv */
`timescale 1ns/1ps

module tbCpuMicrosequencer;

	import z80OpcodePkg::*;
	import ucodePkg::*;

	localparam int ClockPeriod = 8;
	localparam int ResetCycles = 5;
	localparam int FillerCount = 24;
	localparam int CyclesPerOp = 200;
	// Directed ops, jumps, CB pairs, unknown bytes, filler and two closing NOPs
	localparam int NumIssued = 9 + 6 + 8 + 2 + FillerCount + 2;
	localparam uop_t NopUop = uop_t'{FcIncEof, CmdNop, OpdNull};

	logic    clock;
	logic    reset;
	opcode_t mop;
	flags_t  flags;
	uop_t    uop;
	logic    pcIncrement;
	logic    flowEnd;

	// Reference model of the flow in progress
	opcode_t curOp;
	opcode_t cbOp;
	logic    inCb;
	int      step;
	uop_t    expUop;
	logic    expEnd;
	logic    expInc;
	integer  seed;
	opcode_t keptOps [0:8];

	cpuMicrosequencer #(.UcodeAddrWidth(9)) i_cpuMicrosequencer
	(
		.clock(clock), .reset(reset), .mop(mop), .flags(flags),
		.uop(uop), .pcIncrement(pcIncrement), .flowEnd(flowEnd)
	);

	task automatic stopOnFailure(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] got);
		stopOnFailure($sformatf("Error, %0t, %s, expected %0h, got %0h",
			$time, name, expected, got));
	endtask

	// Expected uop at step idx of a flow, written out from the flow table
	function automatic uop_t planUop(input opcode_t op, input opcode_t cb, input logic cbFlow,
		input int idx);
		uop_t seq [0:5];
		// Default flow, also where unknown CB bytes land
		seq = '{uop_t'{FcUpdateFlags, CmdZ801bop, OpdA}, NopUop, NopUop, NopUop, NopUop, NopUop};
		if (cbFlow)
		begin
			if (cb == CbBit7H)
				seq[0] = '{FcEofFu, CmdBit, OpdNull};
			else if (cb == CbRlB || cb == CbSrlB)
			begin
				seq[0] = '{FcUpdateFlags, (cb == CbRlB) ? CmdShl : CmdShr, OpdNull};
				seq[1] = '{FcEof, CmdNop, OpdNull};
			end
		end
		else
		begin
			case (op)
				OpNop:  seq[0] = NopUop;
				OpDi:   seq[0] = '{FcIncEof, CmdCeti, OpdNull};
				OpIncC: seq[0] = '{FcIncEofFu, CmdInc16, OpdC};
				OpDecA: seq[0] = '{FcIncEofFu, CmdDec16, OpdA};
				OpLdAn, OpLdBn, OpLdCn:
				begin
					seq[0] = '{FcInc, CmdSma, OpdPc};
					seq[1] = '{FcInc, CmdNop, OpdNull};
					seq[2] = '{FcEof, CmdSrm, (op == OpLdAn) ? OpdA : (op == OpLdBn) ? OpdB : OpdC};
				end
				OpAddB, OpSubB:
				begin
					seq[0] = '{FcOp, CmdSx16r, OpdA};
					seq[1] = '{FcUpdateFlags, (op == OpAddB) ? CmdAddx16u : CmdSubx16, OpdB};
					seq[2] = '{FcIncEof, CmdSrm, OpdA};
				end
				OpJr, OpJrNz, OpJrZ, OpCbPrefix:
				begin
					seq[0] = '{FcInc, CmdSma, OpdPc};
					seq[1] = '{FcOp, CmdNop, OpdNull};
					seq[2] = '{FcInc, CmdSrm, OpdX8};
					seq[3] = '{FcOp, CmdSx16r, OpdPc};
					seq[4] = '{FcOp, CmdAddx16, OpdX8};
					seq[5] = '{FcEof, CmdSpc, OpdX16};
					if (op == OpJrNz)
						seq[2].flowCtl = FcIncEofZ;
					if (op == OpJrZ)
						seq[2].flowCtl = FcIncEofNz;
					// Prefix shares the byte fetch, then jumps into the CB table
					if (op == OpCbPrefix)
						seq[2] = '{FcJcb, CmdNop, OpdNull};
				end
				// Anything else keeps the default flow
				default: ;
			endcase
		end
		return seq[idx];
	endfunction

	always_comb
	begin
		expUop = planUop(curOp, cbOp, inCb, step);
		expInc = expUop.flowCtl inside {FcInc, FcIncEof, FcIncEofFu, FcIncEofZ, FcIncEofNz, FcJcb};
		case (expUop.flowCtl)
			FcEof, FcIncEof, FcEofFu, FcIncEofFu: expEnd = 1'b1;
			FcIncEofZ:  expEnd = flags.zero;
			FcIncEofNz: expEnd = !flags.zero;
			default:    expEnd = 1'b0;
		endcase
	end

	always @(posedge clock)
	begin
		if (reset)
		begin
			curOp <= OpNop;
			inCb  <= 1'b0;
			step  <= 0;
		end
		else if (expEnd)
		begin
			// Bus byte on the ending edge picks the next flow
			curOp <= mop;
			inCb  <= 1'b0;
			step  <= 0;
		end
		else if (expUop.flowCtl == FcJcb)
		begin
			cbOp <= mop;
			inCb <= 1'b1;
			step <= 0;
		end
		else
			step <= step + 1;
	end

	//////////////////////////////
	// Checks
	//////////////////////////////
	incQuietInReset: assert property (@(posedge clock) reset |-> !pcIncrement)
		else reportMismatch("pcIncrement", 32'(0), 32'($sampled(pcIncrement)));

	endQuietInReset: assert property (@(posedge clock) reset |-> !flowEnd)
		else reportMismatch("flowEnd", 32'(0), 32'($sampled(flowEnd)));

	nopAfterReset: assert property (@(posedge clock) $fell(reset) |-> uop == NopUop)
		else reportMismatch("uop", 32'(NopUop), 32'($sampled(uop)));

	uopFollowsTable: assert property (@(posedge clock) disable iff (reset) uop == expUop)
		else reportMismatch("uop", 32'($sampled(expUop)), 32'($sampled(uop)));

	endMatches: assert property (@(posedge clock) disable iff (reset) flowEnd == expEnd)
		else reportMismatch("flowEnd", 32'($sampled(expEnd)), 32'($sampled(flowEnd)));

	incMatches: assert property (@(posedge clock) disable iff (reset) pcIncrement == expInc)
		else reportMismatch("pcIncrement", 32'($sampled(expInc)), 32'($sampled(pcIncrement)));

	// Put op on the bus, let the running flow end, then set Z for the new flow
	task automatic issueOp(input opcode_t op, input logic zero);
		mop = op;
		while (!flowEnd)
			@(negedge clock);
		@(negedge clock);
		flags.zero = zero;
	endtask

	// CB byte is taken on the FcJcb edge instead of a flow end
	task automatic issueCbByte(input opcode_t cb);
		mop = cb;
		while (uop.flowCtl != FcJcb)
			@(negedge clock);
		@(negedge clock);
	endtask

	initial
	begin
		clock = 1'b0;
		forever #(ClockPeriod / 2) clock = !clock;
	end

	initial
	begin
		repeat (ResetCycles + CyclesPerOp * NumIssued) @(posedge clock);
		stopOnFailure("Timeout, the instruction stream did not complete");
	end

	initial
	begin
		logic [3:0] pick;
		logic       zeroBit;
		seed = 66055;
		keptOps = '{OpNop, OpDi, OpLdAn, OpLdBn, OpLdCn, OpIncC, OpDecA, OpAddB, OpSubB};
		reset = 1'b1;
		mop = OpNop;
		flags = '0;
		repeat (ResetCycles) @(negedge clock);
		reset = 1'b0;
		// Strobes settle out of reset before the first issue
		@(negedge clock);
		for (pick = 0; pick < 9; pick++)
			issueOp(keptOps[pick], 1'b0);
		// Relative jumps with both zero polarities
		issueOp(OpJr, 1'b0);
		issueOp(OpJr, 1'b1);
		issueOp(OpJrNz, 1'b1);
		issueOp(OpJrNz, 1'b0);
		issueOp(OpJrZ, 1'b0);
		issueOp(OpJrZ, 1'b1);
		// CB pairs, RLC B at the end has no flow of its own
		issueOp(OpCbPrefix, 1'b0);
		issueCbByte(CbBit7H);
		issueOp(OpCbPrefix, 1'b0);
		issueCbByte(CbRlB);
		issueOp(OpCbPrefix, 1'b0);
		issueCbByte(CbSrlB);
		issueOp(OpCbPrefix, 1'b0);
		issueCbByte(8'h00);
		// HALT and RST 38h are not kept
		issueOp(8'h76, 1'b0);
		issueOp(8'hFF, 1'b1);
		repeat (FillerCount)
		begin
			pick = 4'($unsigned($random(seed)) % 9);
			zeroBit = 1'($random(seed));
			issueOp(keptOps[pick], zeroBit);
		end
		issueOp(OpNop, 1'b0);
		issueOp(OpNop, 1'b0);
		@(negedge clock);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* flist.f */
rtl/z80OpcodePkg.sv
rtl/ucodePkg.sv
rtl/opcodeDecodeLut.sv
rtl/cbDecodeLut.sv
rtl/ucodeRom.sv
rtl/ucodeSequencer.sv
rtl/cpuMicrosequencer.sv
tb/tbCpuMicrosequencer.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tbCpuMicrosequencer -f flist.f -o tbSim \
	&& ./obj_dir/tbSim \
	|| exit 1
